// File: Bender.yml
package:
  name: branch_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bp_pkg.sv
      - common/recovery_if.sv
      - hdl/branch_decode.sv
      - predictor/pattern_table.sv
      - predictor/fetch_steer.sv
      - hdl/rollback_arbiter.sv
      - hdl/branch_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/branch_unit_properties.sv
      - bench/branch_unit_tb.sv

// File: bench/branch_unit_properties.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module branch_unit_properties (
  input logic                  clock,
  input logic                  reset,
  input logic [`NUM_LANES-1:0] take_branch,
  input logic [`NUM_LANES-1:0] fetch_valid,
  input logic                  rollback_en
);

  // a rollback squashes the whole fetch group
  a_rollback_masks: assert property (@(posedge clock) disable iff (reset)
    rollback_en |-> fetch_valid == '0)
    else $error("fetch lane valid during rollback");

  a_lane1_masked: assert property (@(posedge clock) disable iff (reset)
    take_branch[0] |-> !fetch_valid[1])   // younger lane behind a taken branch
    else $error("lane 1 valid behind taken lane 0");

endmodule

bind branch_unit branch_unit_properties u_branch_unit_properties (
  .clock       (clock),
  .reset       (reset),
  .take_branch (take_branch),
  .fetch_valid (fetch_valid),
  .rollback_en (rollback_en)
);

// File: bench/branch_unit_tb.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module branch_unit_tb;

  localparam int DECODE_LEN = 80;
  localparam int TRAIN_LEN  = 16;
  localparam int BTB_ROUNDS = 8;
  localparam int ARB_LEN    = 64;
  localparam int LOAD_LEN   = 96;
  localparam int MAX_CYCLES = 2 + DECODE_LEN + TRAIN_LEN + 6 * BTB_ROUNDS + ARB_LEN
                              + LOAD_LEN + 5 * 2 + 1 + 16;   // small margin

  logic                              clock;
  logic                              reset;
  logic [`NUM_LANES-1:0]             fetch_valid_in;
  logic [`NUM_LANES-1:0][63:0]       fetch_pc;
  logic [`NUM_LANES-1:0][31:0]       fetch_inst;
  logic [`NUM_LANES-1:0]             br_done;
  logic [`NUM_LANES-1:0][63:0]       br_pc;
  logic [`NUM_LANES-1:0]             br_taken;
  logic [`NUM_LANES-1:0][63:0]       br_target_pc;
  logic [`NUM_LANES-1:0][63:0]       br_predicted_target;
  bp_pkg::rob_idx_t [`NUM_LANES-1:0] br_rob_idx;
  bp_pkg::fl_idx_t  [`NUM_LANES-1:0] br_fl_idx;
  bp_pkg::lsq_idx_t [`NUM_LANES-1:0] br_sq_idx;
  bp_pkg::lsq_idx_t [`NUM_LANES-1:0] br_lq_idx;
  logic [`NUM_LANES-1:0]             ld_violate;
  logic [`NUM_LANES-1:0][63:0]       ld_replay_pc;
  bp_pkg::rob_idx_t [`NUM_LANES-1:0] ld_rob_idx;
  bp_pkg::fl_idx_t  [`NUM_LANES-1:0] ld_fl_idx;
  bp_pkg::lsq_idx_t [`NUM_LANES-1:0] ld_sq_idx;
  bp_pkg::lsq_idx_t [`NUM_LANES-1:0] ld_lq_idx;
  bp_pkg::rob_idx_t                  rob_tail;
  logic [`NUM_LANES-1:0]             take_branch;
  logic [`NUM_LANES-1:0]             fetch_valid;
  logic [63:0]                       next_fetch_pc;
  logic                              rollback_en;
  bp_pkg::rob_idx_t                  rob_rollback_idx;
  bp_pkg::fl_idx_t                   fl_rollback_idx;
  bp_pkg::lsq_idx_t                  sq_rollback_idx;
  bp_pkg::lsq_idx_t                  lq_rollback_idx;
  bp_pkg::rob_idx_t                  rollback_distance;

  // reference tables and expected outputs
  logic [1:0]                        m_bht [bp_pkg::BH_ENTRIES];
  logic [63:0]                       m_btb [bp_pkg::BH_ENTRIES];
  logic [1:0]                        n_bht [bp_pkg::BH_ENTRIES];
  logic [63:0]                       n_btb [bp_pkg::BH_ENTRIES];
  logic [`NUM_LANES-1:0]             exp_take;
  logic [`NUM_LANES-1:0]             exp_valid;
  logic [63:0]                       exp_next_pc;
  logic                              exp_en;
  bp_pkg::rob_idx_t                  exp_rob;
  bp_pkg::fl_idx_t                   exp_fl;
  bp_pkg::lsq_idx_t                  exp_sq;
  bp_pkg::lsq_idx_t                  exp_lq;
  logic [63:0]                       exp_target;
  bp_pkg::rob_idx_t                  exp_dist;

  logic [31:0] rng_state = 32'h7823c49b;
  int          cycle_count = 0;
  int          mismatches = 0;
  int          tests_run = 0;

  branch_unit u_branch_unit (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [5:0] random_opcode();
    logic [31:0] r;
    r = next_rand();
    case (r[3:0])
      4'd0: return `BR_INST;
      4'd1: return `BSR_INST;
      4'd2: return `JSR_GRP;
      4'd3, 4'd4, 4'd5, 4'd6: return `BLBC_INST | {3'b000, r[10:8]};   // any cond branch
      default: return r[31:26];
    endcase
  endfunction

  // {unconditional, conditional}
  function automatic logic [1:0] branch_class(input logic valid, input logic [31:0] inst);
    if (!valid) begin
      return 2'b00;
    end
    case (inst[31:26])
      `BR_INST, `BSR_INST, `JSR_GRP: return 2'b10;
      `BLBC_INST, `BEQ_INST, `BLT_INST, `BLE_INST,
      `BLBS_INST, `BNE_INST, `BGE_INST, `BGT_INST: return 2'b01;
      default: return 2'b00;
    endcase
  endfunction

  always_comb begin
    logic             c_valid [4];
    bp_pkg::rob_idx_t c_rob [4];
    bp_pkg::fl_idx_t  c_fl [4];
    bp_pkg::lsq_idx_t c_sq [4];
    bp_pkg::lsq_idx_t c_lq [4];
    logic [63:0]      c_tgt [4];
    bp_pkg::rob_idx_t c_dist;
    logic [63:0]      corr;
    logic [63:0]      lane_tgt [`NUM_LANES];
    logic [1:0]       cls;
    bp_pkg::bh_idx_t  idx;
    int               win;
    n_bht = m_bht;
    n_btb = m_btb;
    for (int i = 0; i < `NUM_LANES; i++) begin
      corr         = br_taken[i] ? br_target_pc[i] : br_pc[i] + 64'd4;
      c_valid[i]   = br_done[i] && (br_predicted_target[i] != corr);
      c_rob[i]     = br_rob_idx[i];
      c_fl[i]      = br_fl_idx[i];
      c_sq[i]      = br_sq_idx[i];
      c_lq[i]      = br_lq_idx[i];
      c_tgt[i]     = corr;
      c_valid[i+2] = ld_violate[i];
      c_rob[i+2]   = ld_rob_idx[i];
      c_fl[i+2]    = ld_fl_idx[i];
      c_sq[i+2]    = ld_sq_idx[i];
      c_lq[i+2]    = ld_lq_idx[i];
      c_tgt[i+2]   = ld_replay_pc[i];
    end
    // candidates in tie order: branch 0, branch 1, load 0, load 1
    win      = -1;
    exp_dist = '0;
    for (int k = 0; k < 4; k++) begin
      c_dist = rob_tail - c_rob[k];
      if (c_valid[k] && (win < 0 || c_dist > exp_dist)) begin
        win      = k;
        exp_dist = c_dist;
      end
    end
    exp_en     = win >= 0;
    exp_rob    = '0;
    exp_fl     = '0;
    exp_sq     = '0;
    exp_lq     = '0;
    exp_target = '0;
    if (exp_en) begin
      exp_rob    = c_rob[win];
      exp_fl     = c_fl[win];
      exp_sq     = c_sq[win];
      exp_lq     = c_lq[win];
      exp_target = c_tgt[win];
    end
    for (int i = 0; i < `NUM_LANES; i++) begin
      idx = br_pc[i][`BH_IDX_BITS+1:2];
      if (br_done[i] && br_taken[i]) begin
        n_bht[idx] = (n_bht[idx] == 2'b11) ? 2'b11 : n_bht[idx] + 2'b01;
      end else if (br_done[i]) begin
        n_bht[idx] = (n_bht[idx] == 2'b00) ? 2'b00 : n_bht[idx] - 2'b01;
      end
    end
    if ((win == 0 || win == 1) && br_taken[win]) begin
      n_btb[br_pc[win][`BH_IDX_BITS+1:2]] = br_target_pc[win];
    end
    for (int i = 0; i < `NUM_LANES; i++) begin
      cls         = branch_class(fetch_valid_in[i], fetch_inst[i]);
      idx         = fetch_pc[i][`BH_IDX_BITS+1:2];
      exp_take[i] = cls[1] || (cls[0] && n_bht[idx][1]) || exp_en;
      lane_tgt[i] = n_btb[idx];   // lookup sees the pending update
    end
    exp_valid[0] = fetch_valid_in[0] && !exp_en;
    exp_valid[1] = fetch_valid_in[1] && !exp_en && !exp_take[0];
    if (exp_en) begin
      exp_next_pc = exp_target;
    end else if (exp_take[0]) begin
      exp_next_pc = lane_tgt[0];
    end else if (exp_take[1]) begin
      exp_next_pc = lane_tgt[1];
    end else begin
      exp_next_pc = fetch_pc[1] + 64'd4;
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      for (int e = 0; e < bp_pkg::BH_ENTRIES; e++) begin
        m_bht[e] <= `BHT_RESET;
        m_btb[e] <= `BTB_RESET;
      end
    end else begin
      m_bht <= n_bht;
      m_btb <= n_btb;
    end
  end

  task automatic report_mismatch(input string what);
    mismatches++;
    $display("Mismatch at %0t: %s", $time, what);
  endtask

  a_take: assert property (@(posedge clock) disable iff (reset) take_branch == exp_take)
    else report_mismatch($sformatf("take_branch %b, expected %b",
                                   $sampled(take_branch), $sampled(exp_take)));
  a_valid: assert property (@(posedge clock) disable iff (reset) fetch_valid == exp_valid)
    else report_mismatch($sformatf("fetch_valid %b, expected %b",
                                   $sampled(fetch_valid), $sampled(exp_valid)));
  a_next_pc: assert property (@(posedge clock) disable iff (reset)
                              next_fetch_pc == exp_next_pc)
    else report_mismatch($sformatf("next_fetch_pc %h, expected %h",
                                   $sampled(next_fetch_pc), $sampled(exp_next_pc)));
  a_rb_en: assert property (@(posedge clock) disable iff (reset) rollback_en == exp_en)
    else report_mismatch($sformatf("rollback_en %b, expected %b",
                                   $sampled(rollback_en), $sampled(exp_en)));
  a_rb_fields: assert property (@(posedge clock) disable iff (reset)
      exp_en |-> {rob_rollback_idx, fl_rollback_idx, sq_rollback_idx, lq_rollback_idx,
                  rollback_distance} == {exp_rob, exp_fl, exp_sq, exp_lq, exp_dist})
    else report_mismatch($sformatf("rollback rob %0d dist %0d, expected rob %0d dist %0d",
                                   $sampled(rob_rollback_idx), $sampled(rollback_distance),
                                   $sampled(exp_rob), $sampled(exp_dist)));

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic clear_inputs();
    fetch_valid_in      <= '0;
    fetch_pc            <= '0;
    fetch_inst          <= '0;
    br_done             <= '0;
    br_pc               <= '0;
    br_taken            <= '0;
    br_target_pc        <= '0;
    br_predicted_target <= '0;
    br_rob_idx          <= '0;
    br_fl_idx           <= '0;
    br_sq_idx           <= '0;
    br_lq_idx           <= '0;
    ld_violate          <= '0;
    ld_replay_pc        <= '0;
    ld_rob_idx          <= '0;
    ld_fl_idx           <= '0;
    ld_sq_idx           <= '0;
    ld_lq_idx           <= '0;
    rob_tail            <= '0;
  endtask

  task automatic set_fetch(input int lane, input logic [63:0] pc, input logic [31:0] inst);
    fetch_valid_in[lane] <= 1'b1;
    fetch_pc[lane]       <= pc;
    fetch_inst[lane]     <= inst;
  endtask

  task automatic drive_fetch_random();
    logic [31:0] r;
    for (int i = 0; i < `NUM_LANES; i++) begin
      r                 = next_rand();
      fetch_valid_in[i] <= r[1:0] != 2'b00;
      fetch_pc[i]       <= {16'h0, r[31:16], next_rand() & 32'hffff_fffc};
      fetch_inst[i]     <= {random_opcode(), 26'(next_rand())};
    end
  endtask

  // may_hit lets about half of the branches predict correctly
  task automatic drive_branch(input int lane, input bp_pkg::rob_idx_t rob, input bit may_hit);
    logic [63:0] pc;
    logic [63:0] tgt;
    logic [63:0] corr;
    logic [31:0] r;
    r    = next_rand();
    pc   = {32'h0, next_rand() & 32'h0000_fffc};
    tgt  = {32'h0, next_rand() & 32'hffff_fffc};
    corr = r[0] ? tgt : pc + 64'd4;
    br_done[lane]             <= 1'b1;
    br_pc[lane]               <= pc;
    br_taken[lane]            <= r[0];
    br_target_pc[lane]        <= tgt;
    br_predicted_target[lane] <= (may_hit && r[1]) ? corr : corr ^ 64'h40;
    br_rob_idx[lane]          <= rob;
    br_fl_idx[lane]           <= bp_pkg::fl_idx_t'(r >> 8);
    br_sq_idx[lane]           <= bp_pkg::lsq_idx_t'(r >> 16);
    br_lq_idx[lane]           <= bp_pkg::lsq_idx_t'(r >> 20);
  endtask

  task automatic drive_load(input int lane, input bp_pkg::rob_idx_t rob);
    logic [31:0] r;
    r                  = next_rand();
    ld_violate[lane]   <= 1'b1;
    ld_replay_pc[lane] <= {32'h0, next_rand() & 32'hffff_fffc};
    ld_rob_idx[lane]   <= rob;
    ld_fl_idx[lane]    <= bp_pkg::fl_idx_t'(r >> 4);
    ld_sq_idx[lane]    <= bp_pkg::lsq_idx_t'(r >> 12);
    ld_lq_idx[lane]    <= bp_pkg::lsq_idx_t'(r >> 24);
  endtask

  // shared base makes equal ages common
  function automatic bp_pkg::rob_idx_t pick_rob(input bp_pkg::rob_idx_t base);
    logic [31:0] r;
    r = next_rand();
    return r[0] ? base : bp_pkg::rob_idx_t'(r >> 8);
  endfunction

  task automatic finish_test(input string name, input int first_cycle, input int errors_before);
    @(posedge clock);
    clear_inputs();
    @(posedge clock);
    tests_run++;
    $display("%s: %0d cycles, %0d mismatches", name, cycle_count - first_cycle,
             mismatches - errors_before);
  endtask

  task automatic run_decode();
    int c0;
    int e0;
    c0 = cycle_count;
    e0 = mismatches;
    for (int k = 0; k < DECODE_LEN; k++) begin
      @(posedge clock);
      clear_inputs();
      drive_fetch_random();
    end
    finish_test("decode", c0, e0);
  endtask

  task automatic run_training();
    logic [63:0] pc;
    logic [63:0] tgt;
    logic        taken;
    int          c0;
    int          e0;
    c0  = cycle_count;
    e0  = mismatches;
    pc  = 64'h1000 + 64'd12;
    tgt = 64'h3000;
    for (int k = 0; k < TRAIN_LEN; k++) begin
      @(posedge clock);
      clear_inputs();
      set_fetch(0, pc, {`BEQ_INST, 26'h0});
      set_fetch(1, pc + 64'd4, 32'h0);
      if (k % 4 != 3) begin   // every fourth cycle only looks up
        taken = k < TRAIN_LEN / 2;
        br_done[0]             <= 1'b1;
        br_pc[0]               <= pc;
        br_taken[0]            <= taken;
        br_target_pc[0]        <= tgt;
        br_predicted_target[0] <= taken ? tgt : pc + 64'd4;
      end
    end
    finish_test("counter training", c0, e0);
  endtask

  task automatic run_redirect();
    logic [63:0] q;
    logic [63:0] t;
    int          c0;
    int          e0;
    c0 = cycle_count;
    e0 = mismatches;
    for (int k = 0; k < BTB_ROUNDS; k++) begin
      q = {32'h0, next_rand() & 32'h0000_fffc};
      t = {32'h1, next_rand() & 32'hffff_fffc};
      @(posedge clock);
      clear_inputs();
      br_done[0]             <= 1'b1;
      br_pc[0]               <= q;
      br_taken[0]            <= 1'b1;
      br_target_pc[0]        <= t;
      br_predicted_target[0] <= q + 64'd4;
      rob_tail               <= bp_pkg::rob_idx_t'(next_rand());
      @(posedge clock);
      clear_inputs();
      set_fetch(0, q, {`BR_INST, 26'h0});
      set_fetch(1, q + 64'd4, 32'h0);
      @(posedge clock);
      clear_inputs();
      set_fetch(0, t, 32'h0);
      set_fetch(1, t + 64'd4, 32'h0);
      @(posedge clock);
      clear_inputs();
      set_fetch(0, q - 64'd4, 32'h0);
      set_fetch(1, q, {`BSR_INST, 26'h0});
      @(posedge clock);
      clear_inputs();
      br_done[0]             <= 1'b1;   // taken mispredict behind an older load
      br_pc[0]               <= q;
      br_taken[0]            <= 1'b1;
      br_target_pc[0]        <= t ^ 64'h100;
      br_predicted_target[0] <= q + 64'd4;
      br_rob_idx[0]          <= '1;
      drive_load(0, bp_pkg::rob_idx_t'(1));
      @(posedge clock);
      clear_inputs();
      set_fetch(0, q, {`BR_INST, 26'h0});
      set_fetch(1, q + 64'd4, 32'h0);
    end
    finish_test("target buffer", c0, e0);
  endtask

  task automatic run_branch_arb();
    bp_pkg::rob_idx_t base;
    int               c0;
    int               e0;
    c0 = cycle_count;
    e0 = mismatches;
    for (int k = 0; k < ARB_LEN; k++) begin
      base = bp_pkg::rob_idx_t'(next_rand());
      @(posedge clock);
      clear_inputs();
      drive_fetch_random();
      rob_tail <= bp_pkg::rob_idx_t'(next_rand());
      drive_branch(0, pick_rob(base), 1'b0);
      drive_branch(1, pick_rob(base), 1'b0);
    end
    finish_test("branch arbitration", c0, e0);
  endtask

  task automatic run_load_arb();
    bp_pkg::rob_idx_t base;
    logic [31:0]      r;
    int               c0;
    int               e0;
    c0 = cycle_count;
    e0 = mismatches;
    for (int k = 0; k < LOAD_LEN; k++) begin
      base = bp_pkg::rob_idx_t'(next_rand());
      r    = next_rand();
      @(posedge clock);
      clear_inputs();
      drive_fetch_random();
      rob_tail <= bp_pkg::rob_idx_t'(next_rand());
      if (r[0]) begin
        drive_branch(0, pick_rob(base), 1'b1);
      end
      if (r[1]) begin
        drive_branch(1, pick_rob(base), 1'b1);
      end
      if (r[2] || r[3]) begin
        drive_load(0, pick_rob(base));
      end
      if (r[4]) begin
        drive_load(1, pick_rob(base));
      end
    end
    finish_test("load vs branch", c0, e0);
  endtask

  initial begin
    reset <= 1'b1;
    clear_inputs();
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    run_decode();
    run_training();
    run_redirect();
    run_branch_arb();
    run_load_arb();
    @(posedge clock);
    $display("tests run %0d, mismatches %0d", tests_run, mismatches);
    if (mismatches == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: common/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

`define NUM_LANES    2
`define BH_IDX_BITS  4   // pc[BH_IDX_BITS+1:2] indexes the tables

`define NUM_ROB      32
`define NUM_FL       32
`define NUM_LSQ      8

// conditional branches
`define BLBC_INST    6'h38
`define BEQ_INST     6'h39
`define BLT_INST     6'h3a
`define BLE_INST     6'h3b
`define BLBS_INST    6'h3c
`define BNE_INST     6'h3d
`define BGE_INST     6'h3e
`define BGT_INST     6'h3f

// unconditional
`define BR_INST      6'h30
`define BSR_INST     6'h34
`define JSR_GRP      6'h1a

`define BHT_RESET    2'b01   // weakly not taken
`define BTB_RESET    64'h0

`endif

// File: common/bp_pkg.sv
`include "bp_cfg.svh"

package bp_pkg;

  localparam int ROB_IDX_BITS = $clog2(`NUM_ROB);
  localparam int FL_IDX_BITS  = $clog2(`NUM_FL);
  localparam int LSQ_IDX_BITS = $clog2(`NUM_LSQ);
  localparam int BH_ENTRIES   = 2 ** `BH_IDX_BITS;

  typedef logic [ROB_IDX_BITS-1:0] rob_idx_t;
  typedef logic [FL_IDX_BITS-1:0]  fl_idx_t;
  typedef logic [LSQ_IDX_BITS-1:0] lsq_idx_t;
  typedef logic [`BH_IDX_BITS-1:0] bh_idx_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic [31:0] inst;
  } fetch_lane_t;

  typedef struct packed {
    logic        done;
    logic [63:0] pc;
    logic        taken;
    logic [63:0] target_pc;
    logic [63:0] predicted_target;   // next pc fetch used after this branch
    rob_idx_t    rob_idx;
    fl_idx_t     fl_idx;
    lsq_idx_t    sq_idx;
    lsq_idx_t    lq_idx;
  } branch_result_t;

  typedef struct packed {
    logic        violate;
    logic [63:0] replay_pc;
    rob_idx_t    rob_idx;
    fl_idx_t     fl_idx;
    lsq_idx_t    sq_idx;
    lsq_idx_t    lq_idx;
  } load_violation_t;

  // one rollback candidate
  typedef struct packed {
    logic        valid;
    rob_idx_t    rob_idx;
    fl_idx_t     fl_idx;
    lsq_idx_t    sq_idx;
    lsq_idx_t    lq_idx;
    logic [63:0] target;
  } recovery_req_t;

endpackage

// File: common/recovery_if.sv
`timescale 1ns/100ps

// winning rollback broadcast to fetch and the queues
interface recovery_if;

  logic             en;
  bp_pkg::rob_idx_t rob_idx;
  bp_pkg::fl_idx_t  fl_idx;
  bp_pkg::lsq_idx_t sq_idx;
  bp_pkg::lsq_idx_t lq_idx;
  logic [63:0]      target;     // restart address
  bp_pkg::rob_idx_t distance;   // rob_tail - rob_idx of the winner

  modport source (
    output en, rob_idx, fl_idx, sq_idx, lq_idx, target, distance
  );

  modport sink (
    input en, rob_idx, fl_idx, sq_idx, lq_idx, target, distance
  );

endinterface

// File: flist.f
+incdir+common
common/bp_pkg.sv
common/recovery_if.sv
hdl/branch_decode.sv
predictor/pattern_table.sv
predictor/fetch_steer.sv
hdl/rollback_arbiter.sv
hdl/branch_unit.sv
bench/branch_unit_properties.sv
bench/branch_unit_tb.sv

// File: hdl/branch_decode.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module branch_decode (
  input  bp_pkg::fetch_lane_t   lanes [`NUM_LANES],
  output logic [`NUM_LANES-1:0] is_cond,
  output logic [`NUM_LANES-1:0] is_uncond
);

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      is_cond[i]   = 1'b0;
      is_uncond[i] = 1'b0;
      if (lanes[i].valid) begin
        case (lanes[i].inst[31:26])   // primary opcode
          `BLBC_INST,
          `BEQ_INST,
          `BLT_INST,
          `BLE_INST,
          `BLBS_INST,
          `BNE_INST,
          `BGE_INST,
          `BGT_INST: begin
            is_cond[i] = 1'b1;
          end
          `BR_INST,
          `BSR_INST,
          `JSR_GRP: begin
            is_uncond[i] = 1'b1;
          end
          default: begin
            // not a branch
          end
        endcase
      end
    end
  end

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module branch_unit (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic [`NUM_LANES-1:0]                   fetch_valid_in,
  input  logic [`NUM_LANES-1:0][63:0]             fetch_pc,
  input  logic [`NUM_LANES-1:0][31:0]             fetch_inst,
  input  logic [`NUM_LANES-1:0]                   br_done,
  input  logic [`NUM_LANES-1:0][63:0]             br_pc,
  input  logic [`NUM_LANES-1:0]                   br_taken,
  input  logic [`NUM_LANES-1:0][63:0]             br_target_pc,
  input  logic [`NUM_LANES-1:0][63:0]             br_predicted_target,
  input  bp_pkg::rob_idx_t [`NUM_LANES-1:0]       br_rob_idx,
  input  bp_pkg::fl_idx_t  [`NUM_LANES-1:0]       br_fl_idx,
  input  bp_pkg::lsq_idx_t [`NUM_LANES-1:0]       br_sq_idx,
  input  bp_pkg::lsq_idx_t [`NUM_LANES-1:0]       br_lq_idx,
  input  logic [`NUM_LANES-1:0]                   ld_violate,
  input  logic [`NUM_LANES-1:0][63:0]             ld_replay_pc,
  input  bp_pkg::rob_idx_t [`NUM_LANES-1:0]       ld_rob_idx,
  input  bp_pkg::fl_idx_t  [`NUM_LANES-1:0]       ld_fl_idx,
  input  bp_pkg::lsq_idx_t [`NUM_LANES-1:0]       ld_sq_idx,
  input  bp_pkg::lsq_idx_t [`NUM_LANES-1:0]       ld_lq_idx,
  input  bp_pkg::rob_idx_t                        rob_tail,
  output logic [`NUM_LANES-1:0]                   take_branch,
  output logic [`NUM_LANES-1:0]                   fetch_valid,
  output logic [63:0]                             next_fetch_pc,
  output logic                                    rollback_en,
  output bp_pkg::rob_idx_t                        rob_rollback_idx,
  output bp_pkg::fl_idx_t                         fl_rollback_idx,
  output bp_pkg::lsq_idx_t                        sq_rollback_idx,
  output bp_pkg::lsq_idx_t                        lq_rollback_idx,
  output bp_pkg::rob_idx_t                        rollback_distance
);

  bp_pkg::fetch_lane_t         lanes [`NUM_LANES];
  bp_pkg::branch_result_t      results [`NUM_LANES];
  bp_pkg::load_violation_t     violations [`NUM_LANES];
  logic [`NUM_LANES-1:0]       is_cond, is_uncond, counter_taken;
  logic [`NUM_LANES-1:0][63:0] btb_target;
  logic                        btb_wr_en;
  logic [63:0]                 btb_wr_pc, btb_wr_target;

  recovery_if rec ();

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      lanes[i].valid = fetch_valid_in[i];
      lanes[i].pc    = fetch_pc[i];
      lanes[i].inst  = fetch_inst[i];

      results[i].done             = br_done[i];
      results[i].pc               = br_pc[i];
      results[i].taken            = br_taken[i];
      results[i].target_pc        = br_target_pc[i];
      results[i].predicted_target = br_predicted_target[i];
      results[i].rob_idx          = br_rob_idx[i];
      results[i].fl_idx           = br_fl_idx[i];
      results[i].sq_idx           = br_sq_idx[i];
      results[i].lq_idx           = br_lq_idx[i];

      violations[i].violate   = ld_violate[i];
      violations[i].replay_pc = ld_replay_pc[i];
      violations[i].rob_idx   = ld_rob_idx[i];
      violations[i].fl_idx    = ld_fl_idx[i];
      violations[i].sq_idx    = ld_sq_idx[i];
      violations[i].lq_idx    = ld_lq_idx[i];
    end
  end

  branch_decode u_branch_decode (
    .lanes     (lanes),
    .is_cond   (is_cond),
    .is_uncond (is_uncond)
  );

  pattern_table u_pattern_table (
    .clock         (clock),
    .reset         (reset),
    .lookup_pc     (fetch_pc),
    .results       (results),
    .btb_wr_en     (btb_wr_en),
    .btb_wr_pc     (btb_wr_pc),
    .btb_wr_target (btb_wr_target),
    .counter_taken (counter_taken),
    .btb_target    (btb_target)
  );

  fetch_steer u_fetch_steer (
    .lanes         (lanes),
    .is_cond       (is_cond),
    .is_uncond     (is_uncond),
    .counter_taken (counter_taken),
    .btb_target    (btb_target),
    .rec           (rec.sink),
    .take_branch   (take_branch),
    .fetch_valid   (fetch_valid),
    .next_fetch_pc (next_fetch_pc)
  );

  rollback_arbiter u_rollback_arbiter (
    .results       (results),
    .violations    (violations),
    .rob_tail      (rob_tail),
    .rec           (rec.source),
    .btb_wr_en     (btb_wr_en),
    .btb_wr_pc     (btb_wr_pc),
    .btb_wr_target (btb_wr_target)
  );

  assign rollback_en       = rec.en;
  assign rob_rollback_idx  = rec.rob_idx;
  assign fl_rollback_idx   = rec.fl_idx;
  assign sq_rollback_idx   = rec.sq_idx;
  assign lq_rollback_idx   = rec.lq_idx;
  assign rollback_distance = rec.distance;

endmodule

// File: hdl/rollback_arbiter.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module rollback_arbiter (
  input  bp_pkg::branch_result_t  results [`NUM_LANES],
  input  bp_pkg::load_violation_t violations [`NUM_LANES],
  input  bp_pkg::rob_idx_t        rob_tail,
  recovery_if.source              rec,
  output logic                    btb_wr_en,
  output logic [63:0]             btb_wr_pc,
  output logic [63:0]             btb_wr_target
);

  logic [`NUM_LANES-1:0][63:0] correct_pc;
  logic [`NUM_LANES-1:0]       mispredict;
  bp_pkg::recovery_req_t       br_req [`NUM_LANES];
  bp_pkg::recovery_req_t       ld_req [`NUM_LANES];
  bp_pkg::rob_idx_t            br_dist [`NUM_LANES];
  bp_pkg::rob_idx_t            ld_dist [`NUM_LANES];
  logic                        br_sel, ld_sel, br_wins;
  bp_pkg::recovery_req_t       br_win, ld_win, win;
  bp_pkg::rob_idx_t            br_win_dist, ld_win_dist;

  // a is kept on a tie
  function automatic logic a_is_older(input logic va, input bp_pkg::rob_idx_t da,
                                      input logic vb, input bp_pkg::rob_idx_t db);
    return va && (!vb || da >= db);
  endfunction

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      correct_pc[i] = results[i].taken ? results[i].target_pc : results[i].pc + 64'd4;
      mispredict[i] = results[i].done && (results[i].predicted_target != correct_pc[i]);

      br_req[i]  = '0;
      br_dist[i] = '0;
      if (mispredict[i]) begin
        br_req[i].valid   = 1'b1;
        br_req[i].rob_idx = results[i].rob_idx;
        br_req[i].fl_idx  = results[i].fl_idx;
        br_req[i].sq_idx  = results[i].sq_idx;
        br_req[i].lq_idx  = results[i].lq_idx;
        br_req[i].target  = correct_pc[i];
        br_dist[i]        = rob_tail - results[i].rob_idx;   // wraps mod NUM_ROB
      end

      ld_req[i]  = '0;
      ld_dist[i] = '0;
      if (violations[i].violate) begin
        ld_req[i].valid   = 1'b1;
        ld_req[i].rob_idx = violations[i].rob_idx;
        ld_req[i].fl_idx  = violations[i].fl_idx;
        ld_req[i].sq_idx  = violations[i].sq_idx;
        ld_req[i].lq_idx  = violations[i].lq_idx;
        ld_req[i].target  = violations[i].replay_pc;
        ld_dist[i]        = rob_tail - violations[i].rob_idx;
      end
    end
  end

  // lane pairs first, then branch against load
  assign br_sel      = !a_is_older(br_req[0].valid, br_dist[0], br_req[1].valid, br_dist[1]);
  assign br_win      = br_sel ? br_req[1] : br_req[0];
  assign br_win_dist = br_sel ? br_dist[1] : br_dist[0];

  assign ld_sel      = !a_is_older(ld_req[0].valid, ld_dist[0], ld_req[1].valid, ld_dist[1]);
  assign ld_win      = ld_sel ? ld_req[1] : ld_req[0];
  assign ld_win_dist = ld_sel ? ld_dist[1] : ld_dist[0];

  assign br_wins = a_is_older(br_win.valid, br_win_dist, ld_win.valid, ld_win_dist);
  assign win     = br_wins ? br_win : ld_win;

  assign rec.en       = win.valid;
  assign rec.rob_idx  = win.rob_idx;
  assign rec.fl_idx   = win.fl_idx;
  assign rec.sq_idx   = win.sq_idx;
  assign rec.lq_idx   = win.lq_idx;
  assign rec.target   = win.target;
  assign rec.distance = br_wins ? br_win_dist : ld_win_dist;

  // only a taken mispredict that actually won updates the btb
  assign btb_wr_en     = br_wins && br_win.valid && results[br_sel].taken;
  assign btb_wr_pc     = results[br_sel].pc;
  assign btb_wr_target = results[br_sel].target_pc;

endmodule

// File: predictor/fetch_steer.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module fetch_steer (
  input  bp_pkg::fetch_lane_t         lanes [`NUM_LANES],
  input  logic [`NUM_LANES-1:0]       is_cond,
  input  logic [`NUM_LANES-1:0]       is_uncond,
  input  logic [`NUM_LANES-1:0]       counter_taken,
  input  logic [`NUM_LANES-1:0][63:0] btb_target,
  recovery_if.sink                    rec,
  output logic [`NUM_LANES-1:0]       take_branch,
  output logic [`NUM_LANES-1:0]       fetch_valid,
  output logic [63:0]                 next_fetch_pc
);

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      take_branch[i] = is_uncond[i] || (is_cond[i] && counter_taken[i]) || rec.en;
    end
  end

  // younger lane dropped behind a taken older one
  assign fetch_valid[0] = lanes[0].valid && !rec.en;
  assign fetch_valid[1] = lanes[1].valid && !rec.en && !take_branch[0];

  always_comb begin
    if (rec.en) begin
      next_fetch_pc = rec.target;
    end else if (take_branch[0]) begin
      next_fetch_pc = btb_target[0];
    end else if (take_branch[1]) begin
      next_fetch_pc = btb_target[1];
    end else begin
      next_fetch_pc = lanes[1].pc + 64'd4;   // fall through
    end
  end

endmodule

// File: predictor/pattern_table.sv
`timescale 1ns/100ps
`include "bp_cfg.svh"

module pattern_table (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [`NUM_LANES-1:0][63:0]  lookup_pc,
  input  bp_pkg::branch_result_t       results [`NUM_LANES],
  input  logic                         btb_wr_en,
  input  logic [63:0]                  btb_wr_pc,
  input  logic [63:0]                  btb_wr_target,
  output logic [`NUM_LANES-1:0]        counter_taken,
  output logic [`NUM_LANES-1:0][63:0]  btb_target
);

  logic [bp_pkg::BH_ENTRIES-1:0][1:0]  bht;
  logic [bp_pkg::BH_ENTRIES-1:0][1:0]  next_bht;
  logic [bp_pkg::BH_ENTRIES-1:0][63:0] btb;
  logic [bp_pkg::BH_ENTRIES-1:0][63:0] next_btb;

  // lane 1 trains on top of lane 0
  always_comb begin
    bp_pkg::bh_idx_t idx;
    next_bht = bht;
    for (int i = 0; i < `NUM_LANES; i++) begin
      idx = results[i].pc[`BH_IDX_BITS+1:2];
      if (results[i].done) begin
        if (results[i].taken && next_bht[idx] != 2'b11) begin
          next_bht[idx] = next_bht[idx] + 2'b01;
        end else if (!results[i].taken && next_bht[idx] != 2'b00) begin
          next_bht[idx] = next_bht[idx] - 2'b01;
        end
      end
    end
  end

  always_comb begin
    bp_pkg::bh_idx_t wr_idx;
    wr_idx   = btb_wr_pc[`BH_IDX_BITS+1:2];
    next_btb = btb;
    if (btb_wr_en) begin
      next_btb[wr_idx] = btb_wr_target;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      bht <= {bp_pkg::BH_ENTRIES{`BHT_RESET}};
      btb <= {bp_pkg::BH_ENTRIES{`BTB_RESET}};
    end else begin
      bht <= next_bht;
      btb <= next_btb;
    end
  end

  // lookup sees this cycle's update
  always_comb begin
    bp_pkg::bh_idx_t rd_idx;
    for (int i = 0; i < `NUM_LANES; i++) begin
      rd_idx           = lookup_pc[i][`BH_IDX_BITS+1:2];
      counter_taken[i] = next_bht[rd_idx][1];   // msb set means taken
      btb_target[i]    = next_btb[rd_idx];
    end
  end

endmodule
